// File: cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Byte address width on both Wishbone ports
`define ADDR_W 16
// Every access moves one 16-bit word
`define DATA_W 16

// The address splits into tag, set index and a 4-bit offset
`define TAG_W 6
`define SET_W 6
// Upper three offset bits pick the word inside a block
`define WORD_W 3

// Eight words of sixteen bits make up one block
`define WORDS_PER_BLOCK 8
// Two ways per set give twice as many blocks as sets
`define NUM_SETS 64
`define NUM_BLOCKS 128

`endif

// File: cachePkg.sv
`include "cache_params.svh"

package cachePkg;

   // One 16-bit byte address seen two ways
   // The raw view is what travels on the Wishbone address lines
   // The fields view is what the tag compare and array indexing need
   typedef union packed {
      logic [`ADDR_W-1:0] raw;
      struct packed {
         // Compared against the stored tag of both ways
         logic [`TAG_W-1:0]  tag;
         // Selects one of the 64 sets
         logic [`SET_W-1:0]  set;
         // Word inside the 8-word block
         logic [`WORD_W-1:0] word;
         // Byte select is ignored since every access is a whole word
         logic               byteSel;
      } fields;
   } cacheAddrU;

endpackage

// File: metaDataArray.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module metaDataArray (
   input  logic              clk,
   input  logic              arstN,
   // Combinational read port for the set under lookup
   input  logic [`SET_W-1:0] rdSet,
   output logic [`TAG_W-1:0] tag0,
   output logic [`TAG_W-1:0] tag1,
   output logic              valid0,
   output logic              valid1,
   output logic              lru,
   // Tag write port used when a block fill completes
   input  logic              wrEn,
   input  logic [`SET_W-1:0] wrSet,
   input  logic              wrWay,
   input  logic [`TAG_W-1:0] wrTag,
   // LRU update port used on every hit or fill
   input  logic              lruEn,
   input  logic [`SET_W-1:0] lruSet,
   input  logic              lruVal
);

   // Tag storage indexed by way first and set second
   logic [`TAG_W-1:0]    tagMem [2][`NUM_SETS];
   // One valid bit per block, kept as one vector per way
   logic [`NUM_SETS-1:0] validMem [2];
   // A set's LRU bit names the way that gets evicted next
   logic [`NUM_SETS-1:0] lruMem;

   // Both ways are read at once so the tag compare can run in parallel
   assign tag0   = tagMem[0][rdSet];
   assign tag1   = tagMem[1][rdSet];
   assign valid0 = validMem[0][rdSet];
   assign valid1 = validMem[1][rdSet];
   assign lru    = lruMem[rdSet];

   // Tags carry no meaning until the matching valid bit is set
   always_ff @(posedge clk) begin
      if (wrEn) begin
         tagMem[wrWay][wrSet] <= wrTag;
      end
   end

   // Valid and LRU bits start cleared so the first access to any set misses
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         validMem[0] <= '0;
         validMem[1] <= '0;
         lruMem      <= '0;
      end else begin
         // Writing a tag always makes that block valid
         if (wrEn) begin
            validMem[wrWay][wrSet] <= 1'b1;
         end
         if (lruEn) begin
            lruMem[lruSet] <= lruVal;
         end
      end
   end

endmodule

// File: dataArray.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module dataArray (
   input  logic               clk,
   // Combinational read of one word
   input  logic [`SET_W-1:0]  rdSet,
   input  logic               rdWay,
   input  logic [`WORD_W-1:0] rdWord,
   output logic [`DATA_W-1:0] rdData,
   // Synchronous write of one word per cycle
   input  logic               wrEn,
   input  logic [`SET_W-1:0]  wrSet,
   input  logic               wrWay,
   input  logic [`WORD_W-1:0] wrWord,
   input  logic [`DATA_W-1:0] wrData
);

   // The two ways of a set sit in adjacent blocks
   logic [`DATA_W-1:0] mem [`NUM_BLOCKS][`WORDS_PER_BLOCK];

   // Block number is set times two plus way
   logic [`SET_W:0] rdBlock;
   logic [`SET_W:0] wrBlock;

   assign rdBlock = {rdSet, rdWay};
   assign wrBlock = {wrSet, wrWay};

   // Read data follows the address in the same cycle
   // This lets a hit be answered one cycle after the request
   assign rdData = mem[rdBlock][rdWord];

   // Fill words and write hits both come through this single port
   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[wrBlock][wrWord] <= wrData;
      end
   end

endmodule

// File: cache.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache (
   input  logic                clk,
   input  logic                arstN,
   // Processor side Wishbone classic slave
   input  logic                cpuCyc,
   input  logic                cpuStb,
   input  logic                cpuWe,
   input  cachePkg::cacheAddrU cpuAdr,
   input  logic [`DATA_W-1:0]  cpuDatW,
   output logic [`DATA_W-1:0]  cpuDatR,
   output logic                cpuAck,
   // Request towards the fill FSM
   output logic                fillReq,
   output logic                fillWe,
   output cachePkg::cacheAddrU fillAddr,
   output logic [`DATA_W-1:0]  fillData,
   // Response from the fill FSM
   input  logic                fillWordValid,
   input  logic [`WORD_W-1:0]  fillWordIdx,
   input  logic [`DATA_W-1:0]  fillWord,
   input  logic                fillDone
);
   import cachePkg::*;

   typedef enum logic [1:0] {
      idleS,
      lookupS,
      waitFillS,
      respondS
   } cacheStateT;

   cacheStateT state;

   // Request captured when the processor strobe is first seen
   cacheAddrU          reqAddr;
   logic [`DATA_W-1:0] reqData;
   logic               reqWe;
   logic               reqAccept;
   // Way chosen during lookup and kept for the rest of the access
   logic               selWay;

   logic [`TAG_W-1:0]  tag0;
   logic [`TAG_W-1:0]  tag1;
   logic               valid0;
   logic               valid1;
   logic               lru;
   logic               hit0;
   logic               hit1;
   logic               hit;
   logic               waySel;
   logic               curWay;

   logic               arrWrEn;
   logic [`WORD_W-1:0] arrWrWord;
   logic [`DATA_W-1:0] arrWrData;
   logic               metaWrEn;
   logic               lruEn;

   assign reqAccept = (state == idleS) && cpuCyc && cpuStb;

   // Tag compare against both ways of the set
   assign hit0 = valid0 && (tag0 == reqAddr.fields.tag);
   assign hit1 = valid1 && (tag1 == reqAddr.fields.tag);
   assign hit  = hit0 || hit1;

   // The hitting way wins and the LRU way is the victim on a miss
   assign waySel = hit0 ? 1'b0 : (hit1 ? 1'b1 : lru);
   // Lookup works on the live compare while later states use the latched way
   assign curWay = (state == lookupS) ? waySel : selWay;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= idleS;
      end else begin
         case (state)
            idleS: begin
               if (reqAccept) begin
                  state <= lookupS;
               end
            end
            lookupS: begin
               // A read hit is finished here and everything else needs memory
               state <= (!reqWe && hit) ? idleS : waitFillS;
            end
            waitFillS: begin
               if (fillDone) begin
                  state <= respondS;
               end
            end
            default: begin
               state <= idleS;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reqAccept) begin
         // Drop the byte select so every access is word aligned
         reqAddr.raw <= {cpuAdr.raw[`ADDR_W-1:1], 1'b0};
         reqData     <= cpuDatW;
         reqWe       <= cpuWe;
      end
      if (state == lookupS) begin
         selWay <= waySel;
      end
   end

   // Ack in lookup for a read hit or in respond after the memory side is done
   assign cpuAck = ((state == lookupS) && !reqWe && hit) || (state == respondS);

   // Misses and all writes go to memory and are issued straight from lookup
   assign fillReq  = (state == lookupS) && (reqWe || !hit);
   assign fillWe   = reqWe;
   assign fillAddr = reqAddr;
   assign fillData = reqData;

   // A write hit updates the word in lookup while fill words arrive later
   assign arrWrEn   = ((state == lookupS) && reqWe && hit) ||
                      ((state == waitFillS) && fillWordValid);
   assign arrWrWord = (state == lookupS) ? reqAddr.fields.word : fillWordIdx;
   assign arrWrData = (state == lookupS) ? reqData : fillWord;

   // The new tag becomes valid once the whole block is in place
   assign metaWrEn = (state == waitFillS) && fillDone && !reqWe;
   // After a hit or a fill the other way becomes the next victim
   assign lruEn    = ((state == lookupS) && hit) || metaWrEn;

   metaDataArray u_metaDataArray (
      .clk    (clk),
      .arstN  (arstN),
      .rdSet  (reqAddr.fields.set),
      .tag0   (tag0),
      .tag1   (tag1),
      .valid0 (valid0),
      .valid1 (valid1),
      .lru    (lru),
      .wrEn   (metaWrEn),
      .wrSet  (reqAddr.fields.set),
      .wrWay  (selWay),
      .wrTag  (reqAddr.fields.tag),
      .lruEn  (lruEn),
      .lruSet (reqAddr.fields.set),
      .lruVal (~curWay)
   );

   // Read data goes straight to the processor bus and is sampled with cpuAck
   dataArray u_dataArray (
      .clk    (clk),
      .rdSet  (reqAddr.fields.set),
      .rdWay  (curWay),
      .rdWord (reqAddr.fields.word),
      .rdData (cpuDatR),
      .wrEn   (arrWrEn),
      .wrSet  (reqAddr.fields.set),
      .wrWay  (curWay),
      .wrWord (arrWrWord),
      .wrData (arrWrData)
   );

endmodule

// File: cacheFillFsm.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cacheFillFsm (
   input  logic                clk,
   input  logic                arstN,
   // Request from the cache
   input  logic                fillReq,
   input  logic                fillWe,
   input  cachePkg::cacheAddrU fillAddr,
   input  logic [`DATA_W-1:0]  fillData,
   // Returned words and completion towards the cache
   output logic                fillWordValid,
   output logic [`WORD_W-1:0]  fillWordIdx,
   output logic [`DATA_W-1:0]  fillWord,
   output logic                fillDone,
   // Memory side Wishbone classic master
   output logic                memCyc,
   output logic                memStb,
   output logic                memWe,
   output logic [`ADDR_W-1:0]  memAdr,
   output logic [`DATA_W-1:0]  memDatW,
   input  logic [`DATA_W-1:0]  memDatR,
   input  logic                memAck
);
   import cachePkg::*;

   typedef enum logic {
      idleS,
      busyS
   } fsmStateT;

   fsmStateT state;

   // Latched copy of the request for the length of the transfer
   cacheAddrU          addrQ;
   logic [`DATA_W-1:0] dataQ;
   logic               weQ;
   // Counts the beats of a block fill from word 0 upwards
   logic [`WORD_W-1:0] wordCnt;
   cacheAddrU          beatAddr;
   logic               beatDone;
   logic               lastBeat;

   assign beatDone = memStb && memAck;
   // A write is a single beat and a fill ends on the last word of the block
   assign lastBeat = weQ || (wordCnt == `WORD_W'(`WORDS_PER_BLOCK - 1));

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state    <= idleS;
         wordCnt  <= '0;
         fillDone <= 1'b0;
      end else begin
         fillDone <= 1'b0;
         case (state)
            idleS: begin
               if (fillReq) begin
                  state   <= busyS;
                  wordCnt <= '0;
               end
            end
            default: begin
               // Each ack closes one beat and the next beat follows right away
               if (beatDone) begin
                  if (lastBeat) begin
                     state    <= idleS;
                     fillDone <= 1'b1;
                  end else begin
                     wordCnt <= wordCnt + 1'b1;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == idleS) && fillReq) begin
         addrQ <= fillAddr;
         dataQ <= fillData;
         weQ   <= fillWe;
      end
   end

   // A fill walks the words of the block while a write keeps its own word
   always_comb begin
      beatAddr = addrQ;
      if (!weQ) begin
         beatAddr.fields.word = wordCnt;
      end
      beatAddr.fields.byteSel = 1'b0;
   end

   // The cycle and the strobe span the whole transfer with back to back beats
   assign memCyc  = (state == busyS);
   assign memStb  = (state == busyS);
   assign memWe   = memCyc && weQ;
   assign memAdr  = beatAddr.raw;
   assign memDatW = dataQ;

   // Read data is forwarded in the ack cycle so the cache can store it at once
   assign fillWordValid = beatDone && !weQ;
   assign fillWordIdx   = wordCnt;
   assign fillWord      = memDatR;

endmodule

// File: cacheTop.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cacheTop (
   input  logic               clk,
   input  logic               arstN,
   // Processor Wishbone classic slave port
   input  logic               cpuCyc,
   input  logic               cpuStb,
   input  logic               cpuWe,
   input  logic [`ADDR_W-1:0] cpuAdr,
   input  logic [`DATA_W-1:0] cpuDatW,
   output logic [`DATA_W-1:0] cpuDatR,
   output logic               cpuAck,
   // Memory Wishbone classic master port
   output logic               memCyc,
   output logic               memStb,
   output logic               memWe,
   output logic [`ADDR_W-1:0] memAdr,
   output logic [`DATA_W-1:0] memDatW,
   input  logic [`DATA_W-1:0] memDatR,
   input  logic               memAck
);
   import cachePkg::*;

   // Handshake between the lookup side and the memory side
   logic               fillReq;
   logic               fillWe;
   cacheAddrU          fillAddr;
   logic [`DATA_W-1:0] fillData;
   logic               fillWordValid;
   logic [`WORD_W-1:0] fillWordIdx;
   logic [`DATA_W-1:0] fillWord;
   logic               fillDone;

   cache u_cache (
      .clk           (clk),
      .arstN         (arstN),
      .cpuCyc        (cpuCyc),
      .cpuStb        (cpuStb),
      .cpuWe         (cpuWe),
      .cpuAdr        (cpuAdr),
      .cpuDatW       (cpuDatW),
      .cpuDatR       (cpuDatR),
      .cpuAck        (cpuAck),
      .fillReq       (fillReq),
      .fillWe        (fillWe),
      .fillAddr      (fillAddr),
      .fillData      (fillData),
      .fillWordValid (fillWordValid),
      .fillWordIdx   (fillWordIdx),
      .fillWord      (fillWord),
      .fillDone      (fillDone)
   );

   cacheFillFsm u_cacheFillFsm (
      .clk           (clk),
      .arstN         (arstN),
      .fillReq       (fillReq),
      .fillWe        (fillWe),
      .fillAddr      (fillAddr),
      .fillData      (fillData),
      .fillWordValid (fillWordValid),
      .fillWordIdx   (fillWordIdx),
      .fillWord      (fillWord),
      .fillDone      (fillDone),
      .memCyc        (memCyc),
      .memStb        (memStb),
      .memWe         (memWe),
      .memAdr        (memAdr),
      .memDatW       (memDatW),
      .memDatR       (memDatR),
      .memAck        (memAck)
   );

endmodule

// File: cache_asserts.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_asserts (
   input logic               clk,
   input logic               arstN,
   input logic               cpuStb,
   input logic               cpuAck,
   input logic               memStb,
   input logic               memAck,
   input logic               memWe,
   input logic [`ADDR_W-1:0] memAdr
);

   // Each processor request gets a single ack cycle
   cpuAckPulse: assert property (@(posedge clk) disable iff (!arstN) cpuAck |=> !cpuAck)
      else $error("cpuAck stayed high for more than one cycle");

   // The slave only acks a request that is still strobed
   cpuAckWithStb: assert property (@(posedge clk) disable iff (!arstN) cpuAck |-> cpuStb)
      else $error("cpuAck rose without cpuStb");

   // An ack closes its beat so the strobe drops or moves on to the next word
   memAckEndsBeat: assert property (@(posedge clk) disable iff (!arstN)
      memAck |=> !memStb || !$stable(memAdr))
      else $error("memory beat was not closed by memAck");

   // A waiting beat keeps its strobe, address and direction
   memBeatStable: assert property (@(posedge clk) disable iff (!arstN)
      memStb && !memAck |=> memStb && $stable(memAdr) && $stable(memWe))
      else $error("memory beat changed before memAck");

endmodule

bind cacheTop cache_asserts u_cacheAsserts (
   .clk    (clk),
   .arstN  (arstN),
   .cpuStb (cpuStb),
   .cpuAck (cpuAck),
   .memStb (memStb),
   .memAck (memAck),
   .memWe  (memWe),
   .memAdr (memAdr)
);

// File: cacheTb.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cacheTb;
   import cachePkg::*;

   // About 50 accesses that each may need a full fill at the slowest memory ack
   localparam int TIMEOUT_CYCLES = 4000;

   logic               clk;
   logic               arstN;
   logic               cpuCyc;
   logic               cpuStb;
   logic               cpuWe;
   logic [`ADDR_W-1:0] cpuAdr;
   logic [`DATA_W-1:0] cpuDatW;
   logic [`DATA_W-1:0] cpuDatR;
   logic               cpuAck;
   logic               memCyc;
   logic               memStb;
   logic               memWe;
   logic [`ADDR_W-1:0] memAdr;
   logic [`DATA_W-1:0] memDatW;
   logic [`DATA_W-1:0] memDatR;
   logic               memAck;

   // Memory contents and the expected image, both indexed by byte address
   logic [`DATA_W-1:0] memArr [65536];
   logic [`DATA_W-1:0] refArr [65536];

   integer             seed;
   int                 errorCount;
   int                 checkCount;
   int                 cycleCount;
   int                 readBeats;
   int                 writeBeats;
   int                 ackDelay;
   logic               newBeat;
   logic [`ADDR_W-1:0] readAdrQ [$];
   logic [`ADDR_W-1:0] lastWrAdr;
   logic [`DATA_W-1:0] lastWrData;

   cacheTop u_cacheTop (
      .clk     (clk),
      .arstN   (arstN),
      .cpuCyc  (cpuCyc),
      .cpuStb  (cpuStb),
      .cpuWe   (cpuWe),
      .cpuAdr  (cpuAdr),
      .cpuDatW (cpuDatW),
      .cpuDatR (cpuDatR),
      .cpuAck  (cpuAck),
      .memCyc  (memCyc),
      .memStb  (memStb),
      .memWe   (memWe),
      .memAdr  (memAdr),
      .memDatW (memDatW),
      .memDatR (memDatR),
      .memAck  (memAck)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
         $display("Errors found");
         $finish;
      end
   end

   // Memory slave with a random ack delay of 0 to 3 cycles per beat
   // An ack is dropped on the falling edge after the rising edge that took it
   always @(negedge clk) begin
      if (memAck) begin
         memAck  = 1'b0;
         newBeat = 1'b1;
      end else if (memCyc && memStb) begin
         if (newBeat) begin
            ackDelay = $unsigned($random(seed)) % 4;
            newBeat  = 1'b0;
         end
         if (ackDelay == 0) begin
            memAck = 1'b1;
            if (memWe) begin
               memArr[memAdr] = memDatW;
               lastWrAdr      = memAdr;
               lastWrData     = memDatW;
               writeBeats++;
            end else begin
               memDatR = memArr[memAdr];
               readAdrQ.push_back(memAdr);
               readBeats++;
            end
         end else begin
            ackDelay--;
         end
      end
   end

   task automatic check(input string name, input logic [31:0] got,
                        input logic [31:0] expected);
      checkCount++;
      if (got !== expected) begin
         errorCount++;
         $display("** Error: %s is %h, expected %h", name, got, expected);
      end
   endtask

   function automatic logic [`ADDR_W-1:0] buildAddr(input int tag, input int set,
                                                    input int word);
      cacheAddrU a;
      a.fields.tag     = `TAG_W'(tag);
      a.fields.set     = `SET_W'(set);
      a.fields.word    = `WORD_W'(word);
      a.fields.byteSel = 1'b0;
      return a.raw;
   endfunction

   // One Wishbone classic access, latency counted in cycles up to the ack
   task automatic busAccess(input logic we, input logic [`ADDR_W-1:0] adr,
                            input logic [`DATA_W-1:0] wrData,
                            output logic [`DATA_W-1:0] rdData, output int latency);
      latency = 0;
      @(negedge clk);
      cpuCyc  = 1'b1;
      cpuStb  = 1'b1;
      cpuWe   = we;
      cpuAdr  = adr;
      cpuDatW = wrData;
      do begin
         @(negedge clk);
         latency++;
      end while (!cpuAck);
      rdData = cpuDatR;
      // The memory transfer is over by the time the processor sees its ack
      check("memCyc", 32'(memCyc), 0);
      // The strobe stays up through the ack cycle and drops in the next one
      @(negedge clk);
      cpuCyc = 1'b0;
      cpuStb = 1'b0;
      cpuWe  = 1'b0;
   endtask

   task automatic cpuRead(input logic [`ADDR_W-1:0] adr, output int latency);
      logic [`DATA_W-1:0] data;
      busAccess(1'b0, adr, '0, data, latency);
      check("cpuDatR", 32'(data), 32'(refArr[adr]));
   endtask

   task automatic cpuWrite(input logic [`ADDR_W-1:0] adr, input logic [`DATA_W-1:0] data);
      logic [`DATA_W-1:0] ignored;
      int latency;
      refArr[adr] = data;
      busAccess(1'b1, adr, data, ignored, latency);
   endtask

   task automatic readMissThenHit();
      int latency;
      int rd0;
      readAdrQ.delete();
      rd0 = readBeats;
      cpuRead(buildAddr(3, 1, 2), latency);
      check("fill read beats", 32'(readBeats - rd0), 8);
      check("fill beat count", 32'(readAdrQ.size()), 8);
      // Words come back in order from word 0 of the same block
      for (int i = 0; i < readAdrQ.size(); i++) begin
         check("memAdr", 32'(readAdrQ[i]), 32'(buildAddr(3, 1, i)));
      end
      rd0 = readBeats;
      cpuRead(buildAddr(3, 1, 6), latency);
      check("hit read beats", 32'(readBeats - rd0), 0);
      check("hit latency", 32'(latency), 1);
   endtask

   task automatic lruEviction();
      logic [`ADDR_W-1:0] addrA;
      logic [`ADDR_W-1:0] addrB;
      logic [`ADDR_W-1:0] addrC;
      logic [`ADDR_W-1:0] victim;
      logic [`ADDR_W-1:0] kept;
      int latency;
      int rd0;
      int useA;
      int useB;
      addrA = buildAddr(1, 5, 0);
      addrB = buildAddr(2, 5, 1);
      addrC = buildAddr(3, 5, 2);
      cpuRead(addrA, latency);
      cpuRead(addrB, latency);
      // Both blocks are now resident
      // Touching B before A leaves B least recently used
      rd0 = readBeats;
      cpuRead(addrB, latency);
      useB = 1;
      cpuRead(addrA, latency);
      useA = 2;
      check("resident read beats", 32'(readBeats - rd0), 0);
      victim = (useA < useB) ? addrA : addrB;
      kept   = (useA < useB) ? addrB : addrA;
      rd0 = readBeats;
      cpuRead(addrC, latency);
      check("third tag read beats", 32'(readBeats - rd0), 8);
      // The kept block is read first so the victim fill does not evict it
      rd0 = readBeats;
      cpuRead(kept, latency);
      check("kept read beats", 32'(readBeats - rd0), 0);
      rd0 = readBeats;
      cpuRead(victim, latency);
      check("evicted read beats", 32'(readBeats - rd0), 8);
   endtask

   task automatic writeHitThrough();
      logic [`ADDR_W-1:0] addr;
      int latency;
      int rd0;
      int wr0;
      addr = buildAddr(7, 9, 4);
      cpuRead(addr, latency);
      rd0 = readBeats;
      wr0 = writeBeats;
      cpuWrite(addr, 16'hbeef);
      check("write hit write beats", 32'(writeBeats - wr0), 1);
      check("write hit read beats", 32'(readBeats - rd0), 0);
      check("memAdr", 32'(lastWrAdr), 32'(addr));
      check("memDatW", 32'(lastWrData), 32'h0000beef);
      cpuRead(addr, latency);
      check("read after write beats", 32'(readBeats - rd0), 0);
      check("read after write latency", 32'(latency), 1);
   endtask

   task automatic writeMissNoAllocate();
      logic [`ADDR_W-1:0] addr;
      int latency;
      int rd0;
      int wr0;
      addr = buildAddr(10, 12, 3);
      rd0  = readBeats;
      wr0  = writeBeats;
      cpuWrite(addr, 16'h1234);
      check("write miss write beats", 32'(writeBeats - wr0), 1);
      check("write miss read beats", 32'(readBeats - rd0), 0);
      check("memDatW", 32'(lastWrData), 32'h00001234);
      rd0 = readBeats;
      cpuRead(addr, latency);
      check("read after write miss beats", 32'(readBeats - rd0), 8);
   endtask

   // Four tags over four sets force hits, misses and evictions in two ways
   task automatic randomTraffic(input int count);
      int tag;
      int set;
      int word;
      int latency;
      for (int i = 0; i < count; i++) begin
         tag  = $unsigned($random(seed)) % 4;
         set  = 20 + $unsigned($random(seed)) % 4;
         word = $unsigned($random(seed)) % 8;
         if ($unsigned($random(seed)) % 3 == 0) begin
            cpuWrite(buildAddr(tag, set, word), 16'($random(seed)));
         end else begin
            cpuRead(buildAddr(tag, set, word), latency);
         end
      end
   endtask

   initial begin
      seed       = 32'hea41361a;
      errorCount = 0;
      checkCount = 0;
      cycleCount = 0;
      readBeats  = 0;
      writeBeats = 0;
      ackDelay   = 0;
      newBeat    = 1'b1;
      clk        = 1'b0;
      arstN      = 1'b0;
      cpuCyc     = 1'b0;
      cpuStb     = 1'b0;
      cpuWe      = 1'b0;
      cpuAdr     = '0;
      cpuDatW    = '0;
      memDatR    = '0;
      memAck     = 1'b0;
      for (int i = 0; i < 65536; i++) begin
         memArr[16'(i)] = 16'(i) ^ 16'h5a5a;
         refArr[16'(i)] = 16'(i) ^ 16'h5a5a;
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;
      readMissThenHit();
      lruEviction();
      writeHitThrough();
      writeMissNoAllocate();
      randomTraffic(40);
      repeat (2) @(negedge clk);
      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: all.f
+incdir+.
cachePkg.sv
metaDataArray.sv
dataArray.sv
cache.sv
cacheFillFsm.sv
cacheTop.sv
cache_asserts.sv
cacheTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cacheTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
